//--- rtl/rv_pkg.sv
// rv32i core package
// opcodes, alu operation codes, operand select codes, immediate
// formats and the instruction word views shared by the core blocks

package rv_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    // msb is funct7 bit 30, low three bits are funct3
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_fmt_e;

    // alu operand a source
    typedef enum logic {
        alu_a_rs1 = 1'b0,
        alu_a_pc  = 1'b1
    } alu_a_sel_e;

    // alu operand b source
    typedef enum logic [1:0] {
        alu_b_rs2  = 2'b00,
        alu_b_imm  = 2'b01,
        alu_b_four = 2'b10
    } alu_b_sel_e;

    // next pc addend and base
    typedef enum logic {
        pc_a_four = 1'b0,
        pc_a_imm  = 1'b1
    } pc_a_sel_e;

    typedef enum logic {
        pc_b_pc  = 1'b0,
        pc_b_rs1 = 1'b1
    } pc_b_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // stores and branches split their immediate around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_sb_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_uj_t;

    // one fetched word, several decodings
    typedef union packed {
        inst_r_t  r;
        inst_i_t  i;
        inst_sb_t sb;
        inst_uj_t uj;
    } inst_u;

endpackage

//--- rtl/control_unit.sv
// main decoder of the core
// maps opcode and funct fields to operand, alu and pc selects,
// resolves branch conditions from the alu flags

`timescale 1ns/1ps

module control_unit (
    input  logic [6:0]           opcode,
    input  logic [2:0]           funct3,
    input  logic                 funct7_b30,
    input  logic [4:0]           rd,
    input  logic                 less,
    input  logic                 zero,
    output rv_pkg::imm_fmt_e     imm_fmt,
    output rv_pkg::alu_op_e      alu_op,
    output rv_pkg::alu_a_sel_e   alu_a_sel,
    output rv_pkg::alu_b_sel_e   alu_b_sel,
    output rv_pkg::pc_a_sel_e    pc_a_sel,
    output rv_pkg::pc_b_sel_e    pc_b_sel,
    output logic                 clear_lsb,
    output logic                 reg_wen
);

    logic writes;
    logic taken;

    // branch condition, funct3 bit 0 inverts the test
    always_comb begin
        case (funct3[2:1])
            2'b00:   taken = zero;
            2'b10,
            2'b11:   taken = less;
            default: taken = 1'b0;
        endcase
        if (funct3[2:1] != 2'b01) begin
            taken = taken ^ funct3[0];
        end
    end

    always_comb begin
        // defaults give a no-op with sequential pc
        imm_fmt   = rv_pkg::imm_i;
        alu_op    = rv_pkg::alu_add;
        alu_a_sel = rv_pkg::alu_a_rs1;
        alu_b_sel = rv_pkg::alu_b_rs2;
        pc_a_sel  = rv_pkg::pc_a_four;
        pc_b_sel  = rv_pkg::pc_b_pc;
        clear_lsb = 1'b0;
        writes    = 1'b0;

        case (opcode)
            rv_pkg::opc_op: begin
                // bit 30 only legal on add/sub and srl/sra
                if (!funct7_b30 || funct3 == 3'b000 || funct3 == 3'b101) begin
                    alu_op = rv_pkg::alu_op_e'({funct7_b30, funct3});
                    writes = 1'b1;
                end
            end
            rv_pkg::opc_op_imm: begin
                alu_b_sel = rv_pkg::alu_b_imm;
                // bit 30 is immediate data except on shifts
                if (funct3 == 3'b101) begin
                    alu_op = rv_pkg::alu_op_e'({funct7_b30, funct3});
                    writes = 1'b1;
                end else if (funct3 != 3'b001 || !funct7_b30) begin
                    alu_op = rv_pkg::alu_op_e'({1'b0, funct3});
                    writes = 1'b1;
                end
            end
            rv_pkg::opc_lui: begin
                // rs1 port reads x0 for u format, so add passes imm
                imm_fmt   = rv_pkg::imm_u;
                alu_b_sel = rv_pkg::alu_b_imm;
                writes    = 1'b1;
            end
            rv_pkg::opc_auipc: begin
                imm_fmt   = rv_pkg::imm_u;
                alu_a_sel = rv_pkg::alu_a_pc;
                alu_b_sel = rv_pkg::alu_b_imm;
                writes    = 1'b1;
            end
            rv_pkg::opc_jal: begin
                // link value pc + 4 goes through the alu
                imm_fmt   = rv_pkg::imm_j;
                alu_a_sel = rv_pkg::alu_a_pc;
                alu_b_sel = rv_pkg::alu_b_four;
                pc_a_sel  = rv_pkg::pc_a_imm;
                writes    = 1'b1;
            end
            rv_pkg::opc_jalr: begin
                imm_fmt   = rv_pkg::imm_i;
                alu_a_sel = rv_pkg::alu_a_pc;
                alu_b_sel = rv_pkg::alu_b_four;
                pc_a_sel  = rv_pkg::pc_a_imm;
                pc_b_sel  = rv_pkg::pc_b_rs1;
                clear_lsb = 1'b1;
                writes    = 1'b1;
            end
            rv_pkg::opc_branch: begin
                imm_fmt = rv_pkg::imm_b;
                // beq/bne compare by subtraction
                case (funct3[2:1])
                    2'b00:   alu_op = rv_pkg::alu_sub;
                    2'b10:   alu_op = rv_pkg::alu_slt;
                    default: alu_op = rv_pkg::alu_sltu;
                endcase
                if (taken) begin
                    pc_a_sel = rv_pkg::pc_a_imm;
                end
            end
            default: begin
                // unsupported, retire as no-op
                writes = 1'b0;
            end
        endcase
    end

    // x0 never written
    assign reg_wen = writes && (rd != 5'd0);

endmodule

//--- rtl/imm_decoder.sv
// immediate decoder
// gathers the scattered immediate bits of the selected format
// into one sign-extended 32-bit value

`timescale 1ns/1ps

module imm_decoder (
    input  rv_pkg::inst_u    inst,
    input  rv_pkg::imm_fmt_e imm_fmt,
    output logic [31:0]      imm
);

    always_comb begin
        case (imm_fmt)
            rv_pkg::imm_i: begin
                imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
            end
            rv_pkg::imm_s: begin
                imm = {{20{inst.sb.imm_hi[6]}}, inst.sb.imm_hi, inst.sb.imm_lo};
            end
            rv_pkg::imm_b: begin
                // bit 11 sits in imm_lo[0], lsb always zero
                imm = {{19{inst.sb.imm_hi[6]}}, inst.sb.imm_hi[6], inst.sb.imm_lo[0],
                       inst.sb.imm_hi[5:0], inst.sb.imm_lo[4:1], 1'b0};
            end
            rv_pkg::imm_u: begin
                imm = {inst.uj.imm20, 12'b0};
            end
            rv_pkg::imm_j: begin
                // imm20 holds [20|10:1|11|19:12]
                imm = {{11{inst.uj.imm20[19]}}, inst.uj.imm20[19], inst.uj.imm20[7:0],
                       inst.uj.imm20[8], inst.uj.imm20[18:9], 1'b0};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

//--- rtl/register_file.sv
// integer register file
// 32 x 32-bit, two asynchronous read ports and one write port,
// x0 always reads as zero

`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    // write lands on the retiring edge
    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 forced to zero on read
    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

endmodule

//--- rtl/alu.sv
// integer alu
// add, sub, shifts, set-less-than and logic operations,
// with compare and zero flags for branch resolution

`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_op_e alu_op,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    output logic [31:0]     result,
    output logic            less,
    output logic            zero
);

    logic [4:0] shamt;
    logic       less_s;
    logic       less_u;

    assign shamt  = b[4:0];
    assign less_s = $signed(a) < $signed(b);
    assign less_u = a < b;

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_slt:  result = {31'd0, less_s};
            rv_pkg::alu_sltu: result = {31'd0, less_u};
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_srl:  result = a >> shamt;
            // arithmetic shift keeps the sign
            rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_and:  result = a & b;
            default:          result = 32'd0;
        endcase
    end

    // unsigned only for sltu, signed otherwise
    assign less = (alu_op == rv_pkg::alu_sltu) ? less_u : less_s;
    assign zero = (result == 32'd0);

endmodule

//--- rtl/pc_unit.sv
// program counter
// next pc is a + b, lsb cleared for jalr targets,
// pc loads reset_pc on reset and the next pc every edge

`timescale 1ns/1ps

module pc_unit #(
    parameter logic [31:0] reset_pc = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic        clear_lsb,
    output logic [31:0] pc,
    output logic [31:0] dnpc
);

    logic [31:0] sum;

    assign sum  = a + b;
    assign dnpc = {sum[31:1], sum[0] & ~clear_lsb};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

//--- rtl/rv_core.sv
// single-cycle rv32i core top
// splits the fetched word, muxes alu and pc operands, and exposes
// the register write and next pc of each retiring instruction

`timescale 1ns/1ps

module rv_core #(
    parameter logic [31:0] reset_pc = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_rdata,
    output logic        wb_en,
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_data,
    output logic [31:0] dnpc
);

    rv_pkg::inst_u      inst;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [4:0]         rd;
    logic [31:0]        rs1_data;
    logic [31:0]        rs2_data;
    logic [31:0]        imm;
    logic [31:0]        pc;
    logic [31:0]        alu_a;
    logic [31:0]        alu_b;
    logic [31:0]        alu_result;
    logic [31:0]        pc_a;
    logic [31:0]        pc_b;
    logic               less;
    logic               zero;
    logic               reg_wen;
    logic               clear_lsb;
    rv_pkg::imm_fmt_e   imm_fmt;
    rv_pkg::alu_op_e    alu_op;
    rv_pkg::alu_a_sel_e alu_a_sel;
    rv_pkg::alu_b_sel_e alu_b_sel;
    rv_pkg::pc_a_sel_e  pc_a_sel;
    rv_pkg::pc_b_sel_e  pc_b_sel;

    // fetch is a plain combinational read at pc
    assign imem_addr = pc;
    assign inst      = imem_rdata;

    // u format has no rs1 field, read x0 so lui is 0 + imm
    assign rs1 = (imm_fmt == rv_pkg::imm_u) ? 5'd0 : inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd  = inst.r.rd;

    control_unit u_control_unit (
        .opcode     (inst.r.opcode),
        .funct3     (inst.r.funct3),
        .funct7_b30 (inst.r.funct7[5]),
        .rd         (rd),
        .less       (less),
        .zero       (zero),
        .imm_fmt    (imm_fmt),
        .alu_op     (alu_op),
        .alu_a_sel  (alu_a_sel),
        .alu_b_sel  (alu_b_sel),
        .pc_a_sel   (pc_a_sel),
        .pc_b_sel   (pc_b_sel),
        .clear_lsb  (clear_lsb),
        .reg_wen    (reg_wen)
    );

    imm_decoder u_imm_decoder (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // no writes while held in reset
    assign wb_en   = reg_wen & arst_n;
    assign wb_addr = rd;
    assign wb_data = alu_result;

    register_file u_register_file (
        .clk     (clk),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data),
        .wen     (wb_en),
        .waddr   (rd),
        .wdata   (alu_result)
    );

    // alu operand muxes
    assign alu_a = (alu_a_sel == rv_pkg::alu_a_pc) ? pc : rs1_data;

    always_comb begin
        case (alu_b_sel)
            rv_pkg::alu_b_imm:  alu_b = imm;
            rv_pkg::alu_b_four: alu_b = 32'd4;
            default:            alu_b = rs2_data;
        endcase
    end

    alu u_alu (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .less   (less),
        .zero   (zero)
    );

    // next pc operands, offset plus base
    assign pc_a = (pc_a_sel == rv_pkg::pc_a_imm) ? imm : 32'd4;
    assign pc_b = (pc_b_sel == rv_pkg::pc_b_rs1) ? rs1_data : pc;

    pc_unit #(
        .reset_pc (reset_pc)
    ) u_pc_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .a         (pc_a),
        .b         (pc_b),
        .clear_lsb (clear_lsb),
        .pc        (pc),
        .dnpc      (dnpc)
    );

endmodule

//--- tests/tb_clock_gen.sv
// testbench clock and reset source
// 100 ns clock, arst_n held low for a set number of rising edges

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic arst_n
);

    // 50 ns half period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // release lands on a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- tests/tb_rv_core.sv
// testbench for the single-cycle rv32i core
// plays instruction memory from the cases file, one word per cycle,
// and checks fetch address, retire port and next pc of each instruction

`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] reset_pc     = 32'h8000_0000;
    localparam int          reset_cycles = 16;
    localparam int          max_cases    = 64;
    localparam int          fields       = 6;
    localparam int          reset_limit  = 40;
    localparam int          run_limit    = 200;

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic [31:0] dnpc;

    // six words per case in pc, inst, wb_en, wb_addr, wb_data, dnpc order
    logic [31:0] cases [max_cases*fields];
    int          num_cases;
    int          errors;
    int          checks;
    int          edges;
    logic        released;
    logic        finished;

    tb_clock_gen #(
        .reset_cycles (reset_cycles)
    ) u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_core #(
        .reset_pc (reset_pc)
    ) UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .dnpc       (dnpc)
    );

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    initial begin
        int k;
        int i;
        int base;
        // seeded random filler from the very first cycle
        imem_rdata = $urandom(32'h83a98bc9);
        errors     = 0;
        checks     = 0;
        released   = 1'b0;
        finished   = 1'b0;

        // all-ones pc marks the end of the table
        for (k = 0; k < max_cases * fields; k++) begin
            cases[k] = '1;
        end
        $readmemh("tests/rv_core_cases.txt", cases);
        num_cases = 0;
        while (num_cases < max_cases && cases[num_cases*fields] !== 32'hffff_ffff) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            errors++;
            $display("no cases could be read from the cases file");
        end

        // random words during reset must not matter
        edges = 0;
        while (!released && edges < reset_limit) begin
            @(posedge clk);
            edges++;
            // first case goes out on the release edge
            if (edges == reset_cycles) begin
                imem_rdata <= cases[1];
            end else begin
                imem_rdata <= $urandom;
            end
            @(negedge clk);
            if (arst_n) begin
                released = 1'b1;
            end else begin
                compare("reset imem_addr", imem_addr, reset_pc);
                compare("reset wb_en", {31'd0, wb_en}, 32'd0);
            end
        end
        if (!released) begin
            errors++;
            $display("timeout: reset was still active after %0d cycles", reset_limit);
        end

        // each case is checked at the falling edge of its cycle
        for (i = 0; released && i < num_cases; i++) begin
            base = i * fields;
            compare($sformatf("case %0d imem_addr", i), imem_addr, cases[base]);
            compare($sformatf("case %0d wb_en", i), {31'd0, wb_en}, cases[base+2]);
            // retire data only meaningful with a write
            if (cases[base+2][0]) begin
                compare($sformatf("case %0d wb_addr", i), {27'd0, wb_addr}, cases[base+3]);
                compare($sformatf("case %0d wb_data", i), wb_data, cases[base+4]);
            end
            compare($sformatf("case %0d dnpc", i), dnpc, cases[base+5]);
            @(posedge clk);
            if (i + 1 < num_cases) begin
                imem_rdata <= cases[base+fields+1];
            end else begin
                // addi x0, x0, 0 after the last case
                imem_rdata <= 32'h0000_0013;
            end
            @(negedge clk);
        end

        finished = 1'b1;
        $display("cases: %0d, checks: %0d, errors: %0d", num_cases, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog over the whole run
    initial begin
        int cycles;
        cycles = 0;
        while (!finished && cycles < run_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!finished) begin
            $display("timeout: run did not finish within %0d cycles", run_limit);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

//--- tests/rv_core_cases.txt
// columns: pc, instruction, wb_en, wb_addr, wb_data, dnpc (hex)
// wb_addr and wb_data are only checked on lines with wb_en set
80000000 800000B7 1 01 80000000 80000004 // lui   x1, 0x80000
80000004 FF800113 1 02 FFFFFFF8 80000008 // addi  x2, x0, -8
80000008 00500193 1 03 00000005 8000000C // addi  x3, x0, 5
8000000C 00001217 1 04 8000100C 80000010 // auipc x4, 0x1
80000010 003102B3 1 05 FFFFFFFD 80000014 // add   x5, x2, x3
80000014 40218333 1 06 0000000D 80000018 // sub   x6, x3, x2
80000018 003193B3 1 07 000000A0 8000001C // sll   x7, x3, x3
8000001C 00312433 1 08 00000001 80000020 // slt   x8, x2, x3
80000020 003134B3 1 09 00000000 80000024 // sltu  x9, x2, x3
80000024 00314533 1 0A FFFFFFFD 80000028 // xor   x10, x2, x3
80000028 003155B3 1 0B 07FFFFFF 8000002C // srl   x11, x2, x3
8000002C 40315633 1 0C FFFFFFFF 80000030 // sra   x12, x2, x3
80000030 003166B3 1 0D FFFFFFFD 80000034 // or    x13, x2, x3
80000034 00317733 1 0E 00000000 80000038 // and   x14, x2, x3
80000038 00112793 1 0F 00000001 8000003C // slti  x15, x2, 1
8000003C 00113813 1 10 00000000 80000040 // sltiu x16, x2, 1
80000040 FFF1C893 1 11 FFFFFFFA 80000044 // xori  x17, x3, -1
80000044 0F01E913 1 12 000000F5 80000048 // ori   x18, x3, 0xf0
80000048 0FF17993 1 13 000000F8 8000004C // andi  x19, x2, 0xff
8000004C 00419A13 1 14 00000050 80000050 // slli  x20, x3, 4
80000050 01C15A93 1 15 0000000F 80000054 // srli  x21, x2, 28
80000054 40115B13 1 16 FFFFFFFC 80000058 // srai  x22, x2, 1
80000058 00718013 0 00 00000000 8000005C // addi  x0, x3, 7
8000005C 00300BB3 1 17 00000005 80000060 // add   x23, x0, x3
80000060 01718463 0 00 00000000 80000068 // beq   x3, x23, +8 taken
80000068 00218463 0 00 00000000 8000006C // beq   x3, x2, +8
8000006C 00219463 0 00 00000000 80000074 // bne   x3, x2, +8 taken
80000074 01719463 0 00 00000000 80000078 // bne   x3, x23, +8
80000078 00314463 0 00 00000000 80000080 // blt   x2, x3, +8 taken
80000080 0021C463 0 00 00000000 80000084 // blt   x3, x2, +8
80000084 0021D463 0 00 00000000 8000008C // bge   x3, x2, +8 taken
8000008C 00315463 0 00 00000000 80000090 // bge   x2, x3, +8
80000090 0021E463 0 00 00000000 80000098 // bltu  x3, x2, +8 taken
80000098 00316463 0 00 00000000 8000009C // bltu  x2, x3, +8
8000009C 00317463 0 00 00000000 800000A4 // bgeu  x2, x3, +8 taken
800000A4 0021F463 0 00 00000000 800000A8 // bgeu  x3, x2, +8
800000A8 00C00C6F 1 18 800000AC 800000B4 // jal   x24, +12
800000B4 10108CE7 1 19 800000B8 80000100 // jalr  x25, 0x101(x1)
80000100 0030A023 0 00 00000000 80000104 // sw    x3, 0(x1)

//--- filelist.f
rtl/rv_pkg.sv
rtl/control_unit.sv
rtl/imm_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/pc_unit.sv
rtl/rv_core.sv
tests/tb_clock_gen.sv
tests/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rv32i core testbench with verilator, run it, and judge
# the result from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_rv_core -f filelist.f -o tb_rv_core_sim \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/tb_rv_core_sim)
echo "$sim_out"

echo "$sim_out" | grep -q "Verification passed" \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }
